//--- hdl/spi_gpio_consts.svh
// spi gpio bridge constants
// byte and address widths, bank count, register map offsets
`ifndef SPI_GPIO_CONSTS_SVH
`define SPI_GPIO_CONSTS_SVH

// spi byte and register address widths
`define SPI_DATA_W      8
`define SPI_ADDR_W      5

// four banks, one 4-register block each
`define GPIO_NUM_BANKS  4

// offsets inside a bank block
`define GPIO_REG_OE     2'd0
`define GPIO_REG_OUT    2'd1
`define GPIO_REG_IN     2'd2

// command byte layout
`define SPI_WRITE_BIT   7
// shifted out while the command byte comes in
`define SPI_DUMMY_BYTE  8'h5A

`endif

//--- hdl/spi_gpio_pkg.sv
// spi gpio bridge types
// byte, address and bank index vectors plus the byte phase enum
`default_nettype none

`include "spi_gpio_consts.svh"

package spi_gpio_pkg;

	// one shifted byte or one register value
	typedef logic [`SPI_DATA_W-1:0] spi_byte_t;

	// register address from the command byte
	typedef logic [`SPI_ADDR_W-1:0] reg_addr_t;

	// bank number, bits 3:2 of the address
	typedef logic [$clog2(`GPIO_NUM_BANKS)-1:0] bank_idx_t;

	// byte phase inside a frame
	typedef enum logic {
		PHASE_ADDR = 1'b0,
		PHASE_DATA = 1'b1
	} spi_phase_t;

endpackage

`default_nettype wire

//--- hdl/spi_shifter.sv
// spi slave shifter
// synchronizes sclk, cs_n and mosi, shifts bytes msb first, flags each byte
`timescale 1ns/100ps
`default_nettype none

`include "spi_gpio_consts.svh"

module spi_shifter
	import spi_gpio_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_spi_clk,
	input  logic      i_spi_cs_n,
	input  logic      i_spi_mosi,
	input  logic      i_tx_load,
	input  spi_byte_t i_tx_byte,
	output logic      o_spi_miso,
	output logic      o_spi_miso_en,
	output logic      o_byte_done,
	output logic      o_sel_fall,
	output logic      o_sel_rise,
	output spi_byte_t o_rx_byte
);

	// two-flop synchronizers, bit 1 is the safe side
	logic [1:0] sclk_sync;
	logic [1:0] cs_sync;
	logic [1:0] mosi_sync;
	logic sclk_prev;
	logic sclk_rise;
	logic cs_prev;
	logic shift_en;
	// one-hot bit position, all zero once the byte is full
	logic [`SPI_DATA_W-1:0] bit_cnt;
	spi_byte_t shift_r;
	logic byte_done_r;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sclk_sync <= 2'b00;
			cs_sync   <= 2'b11;
			mosi_sync <= 2'b00;
			sclk_prev <= 1'b0;
			sclk_rise <= 1'b0;
			cs_prev   <= 1'b1;
		end else begin
			sclk_sync <= {sclk_sync[0], i_spi_clk};
			cs_sync   <= {cs_sync[0], i_spi_cs_n};
			mosi_sync <= {mosi_sync[0], i_spi_mosi};
			sclk_prev <= sclk_sync[1];
			// registered edge, lands third cycle after the pin edge
			sclk_rise <= sclk_sync[1] & ~sclk_prev;
			cs_prev   <= cs_sync[1];
		end
	end

	// chip select edges for the controller
	assign o_sel_fall = cs_prev & ~cs_sync[1];
	assign o_sel_rise = ~cs_prev & cs_sync[1];

	// only shift while selected
	assign shift_en = sclk_rise & ~cs_sync[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt     <= `SPI_DATA_W'(1);
			shift_r     <= `SPI_DUMMY_BYTE;
			byte_done_r <= 1'b0;
		end else begin
			// pulse one cycle after the eighth edge
			byte_done_r <= shift_en & bit_cnt[`SPI_DATA_W-1];
			if (o_sel_fall) begin
				// new frame always opens with the dummy byte
				bit_cnt <= `SPI_DATA_W'(1);
				shift_r <= `SPI_DUMMY_BYTE;
			end else if (i_tx_load) begin
				bit_cnt <= `SPI_DATA_W'(1);
				shift_r <= i_tx_byte;
			end else if (shift_en) begin
				bit_cnt <= {bit_cnt[`SPI_DATA_W-2:0], 1'b0};
				// mosi enters at the lsb
				shift_r <= {shift_r[`SPI_DATA_W-2:0], mosi_sync[1]};
			end
		end
	end

	assign o_byte_done = byte_done_r;
	assign o_rx_byte   = shift_r;

	// master samples msb at the next rising sclk
	assign o_spi_miso    = shift_r[`SPI_DATA_W-1];
	// stands in for the tri-state buffer
	assign o_spi_miso_en = ~cs_sync[1];

endmodule

`default_nettype wire

//--- hdl/gpio_bank.sv
// gpio bank
// output-enable and output-data registers, synchronized pin input
`timescale 1ns/100ps
`default_nettype none

module gpio_bank
	import spi_gpio_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_wr_en,
	input  logic      i_wr_sel,
	input  spi_byte_t i_wr_data,
	input  spi_byte_t i_pins,
	output spi_byte_t o_oe,
	output spi_byte_t o_out,
	output spi_byte_t o_in
);

	spi_byte_t oe_r;
	spi_byte_t out_r;
	// pin synchronizer stages
	spi_byte_t pin_meta;
	spi_byte_t pin_sync;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			oe_r  <= '0;
			out_r <= '0;
		end else if (i_wr_en) begin
			// sel high picks oe, low picks out
			if (i_wr_sel)
				oe_r <= i_wr_data;
			else
				out_r <= i_wr_data;
		end
	end

	always_ff @(posedge clk) begin
		pin_meta <= i_pins;
		pin_sync <= pin_meta;
	end

	assign o_oe  = oe_r;
	assign o_out = out_r;
	assign o_in  = pin_sync;

endmodule

`default_nettype wire

//--- hdl/spi_cmd_ctrl.sv
// spi command controller
// address/data phase FSM, command latch, write strobes, read-data select
`timescale 1ns/100ps
`default_nettype none

`include "spi_gpio_consts.svh"

module spi_cmd_ctrl
	import spi_gpio_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_byte_done,
	input  logic                           i_sel_fall,
	input  logic                           i_sel_rise,
	input  spi_byte_t                      i_rx_byte,
	input  spi_byte_t [`GPIO_NUM_BANKS-1:0] i_bank_oe,
	input  spi_byte_t [`GPIO_NUM_BANKS-1:0] i_bank_out,
	input  spi_byte_t [`GPIO_NUM_BANKS-1:0] i_bank_in,
	output logic                           o_tx_load,
	output spi_byte_t                      o_tx_byte,
	output logic [`GPIO_NUM_BANKS-1:0]     o_wr_en,
	output logic                           o_wr_sel,
	output spi_byte_t                      o_wr_data
);

	// block index is everything above the 2-bit offset
	localparam int unsigned BLK_W = `SPI_ADDR_W - 2;

	spi_phase_t phase;
	// latched command
	logic      cmd_wr;
	reg_addr_t cmd_addr;
	// read side decodes the byte just received
	reg_addr_t rd_addr;
	logic [BLK_W-1:0] rd_blk;
	bank_idx_t rd_bank;
	logic [1:0] rd_off;
	logic      rd_mapped;
	spi_byte_t rd_data;
	// write side decodes the latched address
	logic [BLK_W-1:0] wr_blk;
	bank_idx_t wr_bank;
	logic [1:0] wr_off;
	logic      wr_mapped;
	logic      wr_fire;
	logic      tx_load_r;
	spi_byte_t tx_byte_r;

	// phase FSM, toggles per byte, back to address on deselect
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			phase <= PHASE_ADDR;
		else if (i_sel_rise)
			phase <= PHASE_ADDR;
		else if (i_byte_done)
			phase <= (phase == PHASE_ADDR) ? PHASE_DATA : PHASE_ADDR;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_wr   <= 1'b0;
			cmd_addr <= '0;
		end else if (i_sel_fall) begin
			// no write carried over from an earlier frame
			cmd_wr <= 1'b0;
		end else if (i_byte_done && phase == PHASE_ADDR) begin
			cmd_wr   <= i_rx_byte[`SPI_WRITE_BIT];
			cmd_addr <= rd_addr;
		end
	end

	assign rd_addr   = i_rx_byte[`SPI_ADDR_W-1:0];
	assign rd_blk    = rd_addr[`SPI_ADDR_W-1:2];
	assign rd_bank   = rd_addr[2 +: $bits(bank_idx_t)];
	assign rd_off    = rd_addr[1:0];
	assign rd_mapped = rd_blk < BLK_W'(`GPIO_NUM_BANKS);

	// register read mux
	always_comb begin
		rd_data = '0;
		if (rd_mapped) begin
			case (rd_off)
				`GPIO_REG_OE:  rd_data = i_bank_oe[rd_bank];
				`GPIO_REG_OUT: rd_data = i_bank_out[rd_bank];
				`GPIO_REG_IN:  rd_data = i_bank_in[rd_bank];
				// offset 3 reads back zero
				default:       rd_data = '0;
			endcase
		end
	end

	assign wr_blk    = cmd_addr[`SPI_ADDR_W-1:2];
	assign wr_bank   = cmd_addr[2 +: $bits(bank_idx_t)];
	assign wr_off    = cmd_addr[1:0];
	assign wr_mapped = wr_blk < BLK_W'(`GPIO_NUM_BANKS);

	// data byte of a write to oe or out
	assign wr_fire = i_byte_done && phase == PHASE_DATA && cmd_wr && wr_mapped &&
		(wr_off == `GPIO_REG_OE || wr_off == `GPIO_REG_OUT);

	always_comb begin
		o_wr_en = '0;
		o_wr_en[wr_bank] = wr_fire;
	end

	assign o_wr_sel  = (wr_off == `GPIO_REG_OE);
	assign o_wr_data = i_rx_byte;

	// load pulse trails byte_done by one cycle, never meets a write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			tx_load_r <= 1'b0;
		else
			tx_load_r <= i_byte_done;
	end

	// next outgoing byte, read value only after a read command
	always_ff @(posedge clk) begin
		if (i_byte_done) begin
			if (phase == PHASE_ADDR && !i_rx_byte[`SPI_WRITE_BIT])
				tx_byte_r <= rd_data;
			else
				tx_byte_r <= `SPI_DUMMY_BYTE;
		end
	end

	assign o_tx_load = tx_load_r;
	assign o_tx_byte = tx_byte_r;

endmodule

`default_nettype wire

//--- hdl/spi_gpio_bridge.sv
// spi to gpio bridge top
// shifter, command controller and the gpio banks
`timescale 1ns/100ps
`default_nettype none

`include "spi_gpio_consts.svh"

module spi_gpio_bridge
	import spi_gpio_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            i_spi_clk,
	input  logic                            i_spi_cs_n,
	input  logic                            i_spi_mosi,
	output logic                            o_spi_miso,
	output logic                            o_spi_miso_en,
	output spi_byte_t [`GPIO_NUM_BANKS-1:0] o_gpio_oe,
	output spi_byte_t [`GPIO_NUM_BANKS-1:0] o_gpio_out,
	input  spi_byte_t [`GPIO_NUM_BANKS-1:0] i_gpio_in
);

	// shifter to controller
	logic      byte_done;
	logic      sel_fall;
	logic      sel_rise;
	spi_byte_t rx_byte;
	logic      tx_load;
	spi_byte_t tx_byte;
	// controller to banks
	logic [`GPIO_NUM_BANKS-1:0] wr_en;
	logic      wr_sel;
	spi_byte_t wr_data;
	// synchronized pin values back from the banks
	spi_byte_t [`GPIO_NUM_BANKS-1:0] bank_in;

	spi_shifter u_shifter (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_spi_clk     (i_spi_clk),
		.i_spi_cs_n    (i_spi_cs_n),
		.i_spi_mosi    (i_spi_mosi),
		.i_tx_load     (tx_load),
		.i_tx_byte     (tx_byte),
		.o_spi_miso    (o_spi_miso),
		.o_spi_miso_en (o_spi_miso_en),
		.o_byte_done   (byte_done),
		.o_sel_fall    (sel_fall),
		.o_sel_rise    (sel_rise),
		.o_rx_byte     (rx_byte)
	);

	spi_cmd_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_byte_done (byte_done),
		.i_sel_fall  (sel_fall),
		.i_sel_rise  (sel_rise),
		.i_rx_byte   (rx_byte),
		.i_bank_oe   (o_gpio_oe),
		.i_bank_out  (o_gpio_out),
		.i_bank_in   (bank_in),
		.o_tx_load   (tx_load),
		.o_tx_byte   (tx_byte),
		.o_wr_en     (wr_en),
		.o_wr_sel    (wr_sel),
		.o_wr_data   (wr_data)
	);

	// banks A to D
	for (genvar b = 0; b < `GPIO_NUM_BANKS; b++) begin : g_bank
		gpio_bank u_bank (
			.clk       (clk),
			.rst_n     (rst_n),
			.i_wr_en   (wr_en[b]),
			.i_wr_sel  (wr_sel),
			.i_wr_data (wr_data),
			.i_pins    (i_gpio_in[b]),
			.o_oe      (o_gpio_oe[b]),
			.o_out     (o_gpio_out[b]),
			.o_in      (bank_in[b])
		);
	end

endmodule

`default_nettype wire

//--- test/spi_gpio_assert.sv
// controller assertions, bound into spi_cmd_ctrl
// tx load and bank writes stay apart, one bank at a time, load only after a byte
`timescale 1ns/100ps
`default_nettype none

`include "spi_gpio_consts.svh"

module spi_gpio_assert (
	input logic                       clk,
	input logic                       rst_n,
	input logic                       i_byte_done,
	input logic                       i_tx_load,
	input logic [`GPIO_NUM_BANKS-1:0] i_wr_en
);

	// failed assertions so far, read by the testbench
	int fail_count = 0;

	a_load_write_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_tx_load && (|i_wr_en)))
		else begin
			fail_count++;
			$error("tx load and bank write strobe in the same cycle");
		end

	a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(i_wr_en))
		else begin
			fail_count++;
			$error("more than one bank write strobe at once");
		end

	// load is the registered byte_done
	a_load_after_done: assert property (@(posedge clk) disable iff (!rst_n)
		i_tx_load |-> $past(i_byte_done))
		else begin
			fail_count++;
			$error("tx load without a byte_done in the cycle before");
		end

endmodule

bind spi_cmd_ctrl spi_gpio_assert u_assert (
	.clk(clk), .rst_n(rst_n), .i_byte_done(i_byte_done),
	.i_tx_load(o_tx_load), .i_wr_en(o_wr_en)
);

`default_nettype wire

//--- test/spi_gpio_checker.sv
// spi gpio checker
// decodes frames from the pins, keeps a register model, compares miso and gpio outputs
`timescale 1ns/100ps
`default_nettype none

`include "spi_gpio_consts.svh"

module spi_gpio_checker
	import spi_gpio_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            i_spi_clk,
	input  logic                            i_spi_cs_n,
	input  logic                            i_spi_mosi,
	input  logic                            i_spi_miso,
	input  logic                            i_spi_miso_en,
	input  spi_byte_t [`GPIO_NUM_BANKS-1:0] i_gpio_oe,
	input  spi_byte_t [`GPIO_NUM_BANKS-1:0] i_gpio_out,
	input  spi_byte_t [`GPIO_NUM_BANKS-1:0] i_gpio_in,
	output logic                            o_busy,
	output int                              o_err_count,
	output int                              o_check_count
);

	spi_byte_t model_oe [`GPIO_NUM_BANKS];
	spi_byte_t model_out [`GPIO_NUM_BANKS];
	spi_byte_t mosi_sr;
	spi_byte_t miso_sr;
	spi_byte_t cmd;
	logic sclk_q;
	logic in_data;
	logic reset_seen;
	int bit_n;
	// cycles left until the gpio outputs are compared
	int wr_wait;

	assign o_busy = (wr_wait != 0);

	task automatic check_byte(input string what, input spi_byte_t got, input spi_byte_t exp);
		o_check_count++;
		if (got !== exp) begin
			o_err_count++;
			$display("mismatch at %0t: %s got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	// blocks 0 to 3 hold oe, out, in; everything else reads zero
	function automatic spi_byte_t read_value(input reg_addr_t addr);
		bank_idx_t bank;
		bank = addr[3:2];
		if (int'(addr >> 2) >= `GPIO_NUM_BANKS)
			return '0;
		case (addr[1:0])
			`GPIO_REG_OE:  return model_oe[bank];
			`GPIO_REG_OUT: return model_out[bank];
			`GPIO_REG_IN:  return i_gpio_in[bank];
			default:       return '0;
		endcase
	endfunction

	task automatic apply_write(input reg_addr_t addr, input spi_byte_t data);
		bank_idx_t bank;
		bank = addr[3:2];
		if (int'(addr >> 2) < `GPIO_NUM_BANKS) begin
			if (addr[1:0] == `GPIO_REG_OE)
				model_oe[bank] = data;
			else if (addr[1:0] == `GPIO_REG_OUT)
				model_out[bank] = data;
		end
	endtask

	task automatic check_outputs(input string when);
		bank_idx_t b;
		for (int i = 0; i < `GPIO_NUM_BANKS; i++) begin
			b = bank_idx_t'(i);
			check_byte($sformatf("%s oe bank %0d", when, i), i_gpio_oe[b], model_oe[b]);
			check_byte($sformatf("%s out bank %0d", when, i), i_gpio_out[b], model_out[b]);
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			model_oe   = '{default: '0};
			model_out  = '{default: '0};
			sclk_q     = 1'b0;
			in_data    = 1'b0;
			reset_seen = 1'b0;
			bit_n      = 0;
			wr_wait    = 0;
		end else begin
			// first cycle out of reset
			if (!reset_seen) begin
				check_outputs("reset");
				check_byte("reset miso enable", spi_byte_t'(i_spi_miso_en), 8'd0);
				reset_seen = 1'b1;
			end
			if (wr_wait != 0) begin
				wr_wait--;
				if (wr_wait == 0)
					check_outputs("write");
			end
			if (i_spi_cs_n) begin
				// deselect puts the next byte back in address phase
				bit_n   = 0;
				in_data = 1'b0;
			end else if (i_spi_clk && !sclk_q) begin
				check_byte("miso enable", spi_byte_t'(i_spi_miso_en), 8'd1);
				mosi_sr = {mosi_sr[`SPI_DATA_W-2:0], i_spi_mosi};
				miso_sr = {miso_sr[`SPI_DATA_W-2:0], i_spi_miso};
				bit_n++;
			end
			if (bit_n == `SPI_DATA_W) begin
				bit_n = 0;
				if (!in_data) begin
					check_byte("command byte miso", miso_sr, `SPI_DUMMY_BYTE);
					cmd = mosi_sr;
				end else if (cmd[`SPI_WRITE_BIT]) begin
					check_byte("write data miso", miso_sr, `SPI_DUMMY_BYTE);
					apply_write(cmd[`SPI_ADDR_W-1:0], mosi_sr);
					// gpio follows 5 clk later, look after 10
					wr_wait = 10;
				end else begin
					check_byte($sformatf("read of %02h", cmd[`SPI_ADDR_W-1:0]), miso_sr,
						read_value(cmd[`SPI_ADDR_W-1:0]));
				end
				in_data = !in_data;
			end
			sclk_q = i_spi_clk;
		end
	end

endmodule

`default_nettype wire

//--- test/tb_spi_gpio.sv
// spi gpio bridge testbench
// random spi master frames into the bridge, results checked by spi_gpio_checker
`timescale 1ns/100ps
`default_nettype none

`include "spi_gpio_consts.svh"

module tb_spi_gpio
	import spi_gpio_pkg::*;
();

	localparam int HALF_SCLK  = 8;
	localparam int NUM_FRAMES = 80;
	localparam int WAIT_LIMIT = 100;

	logic clk;
	logic rst_n;
	logic spi_clk;
	logic spi_cs_n;
	logic spi_mosi;
	logic spi_miso;
	logic spi_miso_en;
	spi_byte_t [`GPIO_NUM_BANKS-1:0] gpio_oe;
	spi_byte_t [`GPIO_NUM_BANKS-1:0] gpio_out;
	spi_byte_t [`GPIO_NUM_BANKS-1:0] gpio_in;
	logic checker_busy;
	int err_count;
	int check_count;
	int timeouts;
	int seed;

	spi_gpio_bridge uut (
		.clk(clk), .rst_n(rst_n), .i_spi_clk(spi_clk), .i_spi_cs_n(spi_cs_n),
		.i_spi_mosi(spi_mosi), .o_spi_miso(spi_miso), .o_spi_miso_en(spi_miso_en),
		.o_gpio_oe(gpio_oe), .o_gpio_out(gpio_out), .i_gpio_in(gpio_in)
	);

	spi_gpio_checker u_checker (
		.clk(clk), .rst_n(rst_n), .i_spi_clk(spi_clk), .i_spi_cs_n(spi_cs_n),
		.i_spi_mosi(spi_mosi), .i_spi_miso(spi_miso), .i_spi_miso_en(spi_miso_en),
		.i_gpio_oe(gpio_oe), .i_gpio_out(gpio_out), .i_gpio_in(gpio_in),
		.o_busy(checker_busy), .o_err_count(err_count), .o_check_count(check_count)
	);

	always #5 clk = ~clk;

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic finish_run();
		int assert_fails;
		assert_fails = uut.u_ctrl.u_assert.fail_count;
		$display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			check_count, err_count, timeouts, assert_fails);
		if (err_count == 0 && timeouts == 0 && assert_fails == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	// miso enable tracks chip select, checker idle once its write check is done
	task automatic wait_settle(input logic en_level);
		int n;
		n = 0;
		while ((spi_miso_en !== en_level || checker_busy) && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (spi_miso_en !== en_level || checker_busy) begin
			$display("timeout at %0t: miso enable not %0b or checker still busy", $time, en_level);
			timeouts++;
		end
	endtask

	// mostly mapped blocks, now and then the unmapped upper half
	function automatic spi_byte_t random_cmd();
		int r;
		r = $random(seed);
		if (r[10:8] != 3'd0)
			r[4] = 1'b0;
		return r[7:0];
	endfunction

	task automatic send_byte(input spi_byte_t b);
		spi_byte_t sr;
		sr = b;
		repeat (`SPI_DATA_W) begin
			// mosi changes while sclk is low
			spi_mosi = sr[`SPI_DATA_W-1];
			sr = sr << 1;
			idle_cycles(HALF_SCLK);
			spi_clk = 1'b1;
			idle_cycles(HALF_SCLK);
			spi_clk = 1'b0;
		end
	endtask

	task automatic run_frame();
		int r;
		int pairs;
		logic cut;
		r = $random(seed);
		pairs = 1 + int'(r[1:0]);
		// about one frame in eight stops after its first command byte
		cut = (r[4:2] == 3'd0);
		// one random word covers the pins of all four banks
		gpio_in = $random(seed);
		idle_cycles(4);
		spi_cs_n = 1'b0;
		wait_settle(1'b1);
		if (timeouts != 0)
			return;
		idle_cycles(HALF_SCLK);
		for (int p = 0; p < pairs; p++) begin
			send_byte(random_cmd());
			if (cut)
				break;
			r = $random(seed);
			send_byte(r[7:0]);
		end
		idle_cycles(HALF_SCLK);
		spi_cs_n = 1'b1;
		wait_settle(1'b0);
	endtask

	initial begin
		seed     = 32'h6a29;
		timeouts = 0;
		clk      = 1'b0;
		rst_n    = 1'b0;
		spi_clk  = 1'b0;
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		gpio_in  = '0;
		idle_cycles(4);
		rst_n = 1'b1;
		idle_cycles(4);
		for (int f = 0; f < NUM_FRAMES && timeouts == 0; f++)
			run_frame();
		idle_cycles(20);
		finish_run();
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/spi_gpio_pkg.sv
hdl/spi_shifter.sv
hdl/gpio_bank.sv
hdl/spi_cmd_ctrl.sv
hdl/spi_gpio_bridge.sv
test/spi_gpio_assert.sv
test/spi_gpio_checker.sv
test/tb_spi_gpio.sv

//--- Makefile
# verilator build and run of the spi gpio bridge testbench
TOP = tb_spi_gpio

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f tb.f -o V$(TOP)

# the run passes only when the log holds the pass line
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^All tests passed!$$" sim.log

clean:
	rm -rf obj_dir sim.log
